// File: common/hack_defines.svh
`ifndef HACK_DEFINES_SVH
`define HACK_DEFINES_SVH

// Data and instruction word width
`define HACK_WORD_W 16

// Program ROM holds 256 instructions
`define HACK_ROM_AW 8

// Address bits decoded inside each data region
`define HACK_RAM_AW 8

// Video scan timing, in clocks
`define HACK_SCAN_PERIOD 64
`define HACK_SCAN_BUSY 20

// Extra cycles of a video access once the scan is quiet
`define HACK_SLOW_WAIT 2

`endif

// File: common/hack_pkg.sv
`include "hack_defines.svh"

package hack_pkg;

  typedef struct packed {
    logic zx;  // Zero x
    logic nx;  // Negate x
    logic zy;  // Zero y
    logic ny;  // Negate y
    logic f;   // Add when set, AND when clear
    logic no;  // Negate the output
  } alu_ctrl_t;

  typedef struct packed {
    logic to_a;
    logic to_d;
    logic to_m;
  } dest_t;

  typedef struct packed {
    logic on_neg;
    logic on_zero;
    logic on_pos;
  } jump_t;

  // Top bit clear means the rest of the word is a constant for A
  typedef struct packed {
    logic                      is_c;
    logic [`HACK_WORD_W-2:0]   value;
  } a_instr_t;

  typedef struct packed {
    logic      is_c;
    logic [1:0] fill;   // Unused, set to ones by the assembler
    logic      a_sel;   // Take the memory operand instead of A
    alu_ctrl_t alu;
    dest_t     dest;
    jump_t     jump;
  } c_instr_t;

  // Both readings keep is_c in the top bit, so either view can pick the form
  typedef union packed {
    a_instr_t a;
    c_instr_t c;
  } instr_u;

  typedef struct packed {
    logic [`HACK_WORD_W-1:0] addr;
    logic [`HACK_WORD_W-1:0] wdata;
    logic                    we;
  } mem_req_t;

  typedef struct packed {
    logic [`HACK_WORD_W-1:0] addr;
    logic [`HACK_WORD_W-1:0] data;
  } store_t;

endpackage

// File: cpu/hack_alu.sv
`timescale 1ns/1ps
`include "hack_defines.svh"

module hack_alu (
  input  logic [`HACK_WORD_W-1:0] x,
  input  logic [`HACK_WORD_W-1:0] y,
  input  hack_pkg::alu_ctrl_t     ctrl,
  output logic [`HACK_WORD_W-1:0] result,
  output logic                    zero,
  output logic                    neg
);

  logic [`HACK_WORD_W-1:0] x_z;
  logic [`HACK_WORD_W-1:0] x_n;
  logic [`HACK_WORD_W-1:0] y_z;
  logic [`HACK_WORD_W-1:0] y_n;
  logic [`HACK_WORD_W-1:0] raw;

  // Operand conditioning happens in a fixed order: zero first, then negate
  assign x_z = ctrl.zx ? '0 : x;
  assign x_n = ctrl.nx ? ~x_z : x_z;
  assign y_z = ctrl.zy ? '0 : y;
  assign y_n = ctrl.ny ? ~y_z : y_z;

  assign raw    = ctrl.f ? (x_n + y_n) : (x_n & y_n);  // Wraps at 16 bits
  assign result = ctrl.no ? ~raw : raw;

  // Flags describe the final result, which is what the jump logic tests
  assign zero = (result == '0);
  assign neg  = result[`HACK_WORD_W-1];

endmodule

// File: cpu/hack_cpu.sv
`timescale 1ns/1ps
`include "hack_defines.svh"

module hack_cpu (
  input  logic                    clk,
  input  logic                    reset,
  input  hack_pkg::instr_u        instr,
  input  logic [`HACK_WORD_W-1:0] rdata,
  input  logic                    busy,
  output logic [`HACK_WORD_W-1:0] pc,
  output hack_pkg::mem_req_t      mem_req,
  output logic                    store_valid,
  output hack_pkg::store_t        store
);

  localparam logic [2:0] st_fetch    = 3'd0;
  localparam logic [2:0] st_decode   = 3'd1;
  localparam logic [2:0] st_exec     = 3'd2;
  localparam logic [2:0] st_mem_read = 3'd3;
  localparam logic [2:0] st_mem_load = 3'd4;

  logic [2:0] state;

  logic [`HACK_WORD_W-1:0] a_reg;
  logic [`HACK_WORD_W-1:0] d_reg;
  logic [`HACK_WORD_W-1:0] m_reg;  // Copy of RAM[A], refreshed after every A write

  hack_pkg::a_instr_t ai;
  hack_pkg::c_instr_t ci;

  logic [`HACK_WORD_W-1:0] alu_y;
  logic [`HACK_WORD_W-1:0] alu_out;
  logic                    alu_zero;
  logic                    alu_neg;
  logic                    alu_pos;
  logic                    take_jump;
  logic                    exec_done;

  // The ROM holds its word stable from decode until pc moves, so exec reads it directly
  assign ai = instr.a;
  assign ci = instr.c;

  assign alu_y = ci.a_sel ? m_reg : a_reg;

  hack_alu i_hack_alu (
    .x      (d_reg),
    .y      (alu_y),
    .ctrl   (ci.alu),
    .result (alu_out),
    .zero   (alu_zero),
    .neg    (alu_neg)
  );

  assign alu_pos   = !(alu_neg || alu_zero);
  assign take_jump = (ci.jump.on_neg && alu_neg) ||
                     (ci.jump.on_zero && alu_zero) ||
                     (ci.jump.on_pos && alu_pos);

  // Only a memory write has to wait for the memory in exec
  assign exec_done = !ci.dest.to_m || !busy;

  always_comb begin
    mem_req.addr  = a_reg;  // The memory is always addressed by A
    mem_req.wdata = alu_out;
    mem_req.we    = (state == st_exec) && ci.is_c && ci.dest.to_m;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_fetch;
      pc          <= '0;
      a_reg       <= '0;
      d_reg       <= '0;
      m_reg       <= '0;
      store_valid <= 1'b0;
    end else begin
      store_valid <= 1'b0;  // Pulse, raised again only by a committed write

      case (state)
        st_fetch: begin
          state <= st_decode;  // ROM word for pc arrives at this edge
        end

        st_decode: begin
          if (ai.is_c) begin
            state <= st_exec;
          end else begin
            a_reg <= {1'b0, ai.value};
            pc    <= pc + 1'b1;
            state <= st_mem_read;
          end
        end

        st_exec: begin
          if (exec_done) begin
            if (ci.dest.to_a) begin
              a_reg <= alu_out;
            end
            if (ci.dest.to_d) begin
              d_reg <= alu_out;
            end
            if (ci.dest.to_m) begin
              m_reg       <= alu_out;  // Keeps the operand coherent with RAM
              store_valid <= 1'b1;
            end

            // Jump target is the value of A before this instruction wrote it
            if (take_jump) begin
              pc <= a_reg;
            end else begin
              pc <= pc + 1'b1;
            end

            // A new address needs a new memory operand before the next instruction
            state <= ci.dest.to_a ? st_mem_read : st_fetch;
          end
        end

        st_mem_read: begin
          if (!busy) begin
            state <= st_mem_load;
          end
        end

        st_mem_load: begin
          m_reg <= rdata;
          state <= st_fetch;
        end

        default: begin
          state <= st_fetch;
        end
      endcase
    end
  end

  // Commit record travels with the store pulse
  always_ff @(posedge clk) begin
    if (state == st_exec && exec_done && ci.dest.to_m) begin
      store.addr <= a_reg;
      store.data <= alu_out;
    end
  end

endmodule

// File: logic/instr_rom.sv
`timescale 1ns/1ps
`include "hack_defines.svh"

module instr_rom (
  input  logic                    clk,
  input  logic                    prog_we,
  input  logic [`HACK_ROM_AW-1:0] prog_addr,
  input  hack_pkg::instr_u        prog_data,
  input  logic [`HACK_WORD_W-1:0] pc,
  output hack_pkg::instr_u        instr
);

  localparam int depth = 1 << `HACK_ROM_AW;

  hack_pkg::instr_u rom [0:depth-1];

  // Host side, used only while the core sits in reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      rom[prog_addr] <= prog_data;
    end
  end

  // Registered fetch, the word shows up one cycle after pc
  always_ff @(posedge clk) begin
    instr <= rom[pc[`HACK_ROM_AW-1:0]];  // Upper pc bits wrap onto the ROM
  end

endmodule

// File: logic/data_mem.sv
`timescale 1ns/1ps
`include "hack_defines.svh"

module data_mem (
  input  logic                    clk,
  input  logic                    reset,
  input  hack_pkg::mem_req_t      mem_req,
  output logic [`HACK_WORD_W-1:0] rdata,
  output logic                    busy
);

  localparam int depth  = 1 << `HACK_RAM_AW;
  localparam int scan_w = $clog2(`HACK_SCAN_PERIOD);
  localparam int wait_w = $clog2(`HACK_SLOW_WAIT + 1);

  logic [`HACK_WORD_W-1:0] fast_ram  [0:depth-1];
  logic [`HACK_WORD_W-1:0] video_ram [0:depth-1];

  logic [scan_w-1:0]       scan_cnt;
  logic [wait_w-1:0]       wait_cnt;
  logic                    scan_busy;
  logic                    slow;
  logic [`HACK_RAM_AW-1:0] idx;

  // Video region is 0x4000..0x5FFF, everything else goes to fast RAM
  assign slow = mem_req.addr[14] && !mem_req.addr[13];
  assign idx  = mem_req.addr[`HACK_RAM_AW-1:0];

  assign scan_busy = (scan_cnt < scan_w'(`HACK_SCAN_BUSY));
  assign busy      = slow && (scan_busy || (wait_cnt != wait_w'(`HACK_SLOW_WAIT)));

  always_ff @(posedge clk) begin
    if (reset || scan_cnt == scan_w'(`HACK_SCAN_PERIOD - 1)) begin
      scan_cnt <= '0;
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

  // Counts quiet cycles of a video access and starts over once it completes
  always_ff @(posedge clk) begin
    if (reset || !slow || scan_busy) begin
      wait_cnt <= '0;
    end else if (wait_cnt == wait_w'(`HACK_SLOW_WAIT)) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset && mem_req.we && !busy) begin
      if (slow) begin
        video_ram[idx] <= mem_req.wdata;
      end else begin
        fast_ram[idx] <= mem_req.wdata;
      end
    end
    if (!busy) begin
      rdata <= slow ? video_ram[idx] : fast_ram[idx];  // Held while the region is busy
    end
  end

endmodule

// File: logic/hack_top.sv
`timescale 1ns/1ps
`include "hack_defines.svh"

module hack_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    prog_we,
  input  logic [`HACK_ROM_AW-1:0] prog_addr,
  input  hack_pkg::instr_u        prog_data,
  output logic [`HACK_WORD_W-1:0] pc,
  output logic                    store_valid,
  output hack_pkg::store_t        store
);

  hack_pkg::instr_u        instr;
  hack_pkg::mem_req_t      mem_req;
  logic [`HACK_WORD_W-1:0] rdata;
  logic                    busy;

  // Program side, loaded by the host while the core is held in reset
  instr_rom i_instr_rom (
    .clk       (clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .pc        (pc),
    .instr     (instr)
  );

  hack_cpu i_hack_cpu (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .rdata       (rdata),
    .busy        (busy),
    .pc          (pc),
    .mem_req     (mem_req),
    .store_valid (store_valid),
    .store       (store)
  );

  // Region decode and video stalls are handled entirely in here
  data_mem i_data_mem (
    .clk     (clk),
    .reset   (reset),
    .mem_req (mem_req),
    .rdata   (rdata),
    .busy    (busy)
  );

endmodule

// File: verif/hack_tb.sv
`timescale 1ns/1ps
`include "hack_defines.svh"

module hack_tb;

  localparam int rom_depth = 1 << `HACK_ROM_AW;
  localparam logic [5:0] comps [0:17] = '{
    6'b101010, 6'b111111, 6'b111010, 6'b001100, 6'b110000, 6'b001101,
    6'b110001, 6'b001111, 6'b110011, 6'b011111, 6'b110111, 6'b001110,
    6'b110010, 6'b000010, 6'b010011, 6'b000111, 6'b000000, 6'b010101};

  logic                    clk;
  logic                    reset;
  logic                    prog_we;
  logic [`HACK_ROM_AW-1:0] prog_addr;
  hack_pkg::instr_u        prog_data;
  logic [`HACK_WORD_W-1:0] pc;
  logic                    store_valid;
  hack_pkg::store_t        store;

  hack_pkg::instr_u        prog [$];
  hack_pkg::instr_u        prog_img [0:rom_depth-1];
  logic [`HACK_WORD_W-1:0] m_a, m_d, m_pc, halt_addr;
  logic [`HACK_WORD_W-1:0] mem_model [int];  // Keyed by region and word index
  string                   test_name;
  int                      mismatch_count, other_count;
  int                      cycle_count, test_start, cycle_limit;
  bit                      in_reset;
  integer                  seed;

  hack_top i_hack_top (
    .clk         (clk),
    .reset       (reset),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .pc          (pc),
    .store_valid (store_valid),
    .store       (store)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic hack_pkg::instr_u a_ins(input logic [14:0] value);
    hack_pkg::instr_u w;
    w.a.is_c  = 1'b0;
    w.a.value = value;
    return w;
  endfunction

  function automatic hack_pkg::instr_u c_ins(input logic a_sel, input logic [5:0] comp,
                                             input logic [2:0] dest, input logic [2:0] jump);
    hack_pkg::instr_u w;
    w.c.is_c  = 1'b1;
    w.c.fill  = 2'b11;
    w.c.a_sel = a_sel;
    w.c.alu   = comp;
    w.c.dest  = dest;  // Bits are A, D, M
    w.c.jump  = jump;
    return w;
  endfunction

  // Video words live at 0x4000..0x5FFF and both regions wrap on the low address bits
  function automatic int mem_key(input logic [`HACK_WORD_W-1:0] addr);
    return ((addr[14] && !addr[13]) ? rom_depth : 0) + int'(addr[`HACK_RAM_AW-1:0]);
  endfunction

  // Meaning of each of the 18 standard comp mnemonics where x is D and y is A or M
  function automatic logic [15:0] alu_ref(input logic [15:0] x, input logic [15:0] y,
                                          input logic [5:0] comp);
    case (comp)
      6'b101010: return 16'd0;
      6'b111111: return 16'd1;
      6'b111010: return 16'hffff;
      6'b001100: return x;
      6'b110000: return y;
      6'b001101: return ~x;
      6'b110001: return ~y;
      6'b001111: return 16'd0 - x;
      6'b110011: return 16'd0 - y;
      6'b011111: return x + 16'd1;
      6'b110111: return y + 16'd1;
      6'b001110: return x - 16'd1;
      6'b110010: return y - 16'd1;
      6'b000010: return x + y;
      6'b010011: return x - y;
      6'b000111: return y - x;
      6'b000000: return x & y;
      default:   return x | y;
    endcase
  endfunction

  // Runs one instruction on the model and reports whether it stored
  function automatic bit hack_step(output hack_pkg::store_t st);
    hack_pkg::instr_u w;
    logic [15:0]      y, r, next_pc;
    bit               take;
    w  = prog_img[m_pc[`HACK_ROM_AW-1:0]];
    st = '0;
    if (!w.a.is_c) begin
      m_a  = {1'b0, w.a.value};
      m_pc = m_pc + 16'd1;
      return 1'b0;
    end
    y    = w.c.a_sel ? mem_model[mem_key(m_a)] : m_a;
    r    = alu_ref(m_d, y, w.c.alu);
    take = (w.c.jump.on_neg && r[15]) || (w.c.jump.on_zero && r == 16'd0) ||
           (w.c.jump.on_pos && !r[15] && r != 16'd0);
    next_pc = take ? m_a : m_pc + 16'd1;  // Target is A before this instruction
    if (w.c.dest.to_m) begin
      mem_model[mem_key(m_a)] = r;
      st.addr = m_a;
      st.data = r;
    end
    if (w.c.dest.to_a) m_a = r;
    if (w.c.dest.to_d) m_d = r;
    m_pc = next_pc;
    return w.c.dest.to_m;
  endfunction

  task automatic compare_store(input hack_pkg::store_t expected, input hack_pkg::store_t actual);
    if (expected !== actual) begin
      mismatch_count++;
      $display("Mismatch in %s: store expected addr %h data %h, actual addr %h data %h",
               test_name, expected.addr, expected.data, actual.addr, actual.data);
    end
  endtask

  task automatic compare_pc(input logic [`HACK_WORD_W-1:0] expected,
                            input logic [`HACK_WORD_W-1:0] actual);
    if (expected !== actual) begin
      mismatch_count++;
      $display("Mismatch in %s: pc expected %h, actual %h", test_name, expected, actual);
    end
  endtask

  task automatic report_error(input string msg);
    other_count++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  task automatic check_next_store();
    hack_pkg::store_t exp;
    int               steps;
    bit               done;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 2000) begin
      if (m_pc == halt_addr) begin
        report_error("a store arrived after the program had halted");
        done = 1'b1;
      end else if (hack_step(exp)) begin
        compare_store(exp, store);
        done = 1'b1;
      end
      steps++;
    end
    if (!done) report_error("the model ran away looking for the next store");
  endtask

  // Every store pulse is matched against the model's next store
  always @(posedge clk) begin
    if (store_valid) begin
      if (reset && in_reset) report_error("a store was reported while reset was high");
      else check_next_store();
    end
    in_reset = reset;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count - test_start > cycle_limit) begin
      $display("Timeout in %s: no halt within %0d cycles", test_name, cycle_limit);
      $display("Mismatches %0d, other errors %0d", mismatch_count, other_count);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic emit_halt();
    halt_addr = 16'(prog.size());
    prog.push_back(a_ins(15'(prog.size())));
    prog.push_back(c_ins(1'b0, 6'b101010, 3'b000, 3'b111));  // 0;JMP back onto itself
  endtask

  task automatic model_reset();
    m_a  = '0;
    m_d  = '0;
    m_pc = '0;
  endtask

  task automatic set_limit();
    int n_slow;
    n_slow = 0;
    foreach (prog[i]) if (!prog[i].a.is_c && prog[i].a.value[14] && !prog[i].a.value[13])
      n_slow++;
    test_start  = cycle_count;
    cycle_limit = prog.size() * 5 + n_slow * 2 * `HACK_SCAN_PERIOD + 200;
  endtask

  task automatic start_program(input string name);
    test_name = name;
    @(posedge clk);
    reset <= 1'b1;
    foreach (prog[i]) begin
      @(posedge clk);
      prog_we     <= 1'b1;
      prog_addr   <= i[`HACK_ROM_AW-1:0];
      prog_data   <= prog[i];
      prog_img[i] = prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    repeat (5) @(posedge clk);
    model_reset();
    set_limit();
    reset <= 1'b0;
  endtask

  // Forward-only programs move pc backwards only in the closing self-jump
  task automatic wait_for_halt();
    logic [`HACK_WORD_W-1:0] prev;
    do begin
      prev = pc;
      @(posedge clk);
    end while (pc >= prev);
  endtask

  task automatic finish_program();
    hack_pkg::store_t exp;
    int               steps;
    wait_for_halt();
    compare_pc(halt_addr, pc);
    steps = 0;
    while (m_pc != halt_addr && steps < 2000) begin
      if (hack_step(exp))
        report_error($sformatf("store of %h to %h never arrived", exp.data, exp.addr));
      steps++;
    end
    cycle_limit = 0;
  endtask

  task automatic build_random(input int n_blocks);
    logic [31:0] r;
    int          target;
    prog.delete();
    for (int b = 0; b < n_blocks; b++) begin
      r = $random(seed);
      if (r % 3 == 0) begin
        target = 2 * (b + 1 + int'(r[9:8] % 3));  // Lands forward on a later block start
        if (target > 2 * n_blocks) target = 2 * n_blocks;
        prog.push_back(a_ins(15'(target)));
        prog.push_back(c_ins(1'b0, comps[r[20:16] % 18], {1'b0, r[5:4]}, r[2:0]));
      end else begin
        prog.push_back(a_ins(r[30:16]));
        prog.push_back(c_ins(1'b0, comps[r[12:8] % 18], {1'b0, r[5:4] | 2'b01}, 3'b000));
      end
    end
    emit_halt();
  endtask

  initial begin
    logic [31:0] r;
    int          base;
    seed = 32'hbde3ffec;
    reset = 1'b1;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    in_reset = 1'b1;
    mismatch_count = 0;
    other_count = 0;
    cycle_count = 0;
    test_start = 0;
    cycle_limit = 0;
    halt_addr = '0;
    model_reset();
    repeat (5) @(posedge clk);

    prog.delete();
    prog = '{a_ins(15'd5), c_ins(1'b0, 6'b110000, 3'b010, 3'b000),
             a_ins(15'd100), c_ins(1'b0, 6'b001100, 3'b001, 3'b000),
             a_ins(15'h1234), c_ins(1'b0, 6'b110000, 3'b001, 3'b000),
             a_ins(15'd300), c_ins(1'b0, 6'b011111, 3'b011, 3'b000)};
    emit_halt();
    start_program("a_instr_store");
    finish_program();

    prog.delete();
    for (int i = 0; i < 18; i++) begin
      r = $random(seed);
      prog.push_back(a_ins(r[14:0]));
      prog.push_back(c_ins(1'b0, 6'b110000, 3'b010, 3'b000));
      if (r[15]) prog.push_back(c_ins(1'b0, 6'b001101, 3'b010, 3'b000));  // Sets D's top bit
      prog.push_back(a_ins(r[30:16]));
      prog.push_back(c_ins(1'b0, comps[i], 3'b001, 3'b000));
    end
    emit_halt();
    start_program("alu_functions");
    finish_program();

    // A taken jump skips the store of 1, so the store order shows the path
    prog.delete();
    for (int code = 0; code < 8; code++) begin
      for (int v = 0; v < 3; v++) begin
        base = prog.size();
        prog.push_back(a_ins(v == 1 ? 15'd0 : 15'd7));
        prog.push_back(c_ins(1'b0, 6'b110000, 3'b010, 3'b000));
        prog.push_back(c_ins(1'b0, v == 0 ? 6'b001111 : 6'b001100, 3'b010, 3'b000));
        prog.push_back(a_ins(15'(base + 7)));
        prog.push_back(c_ins(1'b0, 6'b001100, 3'b000, 3'(code)));
        prog.push_back(a_ins(15'(200 + code * 3 + v)));
        prog.push_back(c_ins(1'b0, 6'b111111, 3'b001, 3'b000));
        prog.push_back(a_ins(15'(200 + code * 3 + v)));
        prog.push_back(c_ins(1'b0, 6'b111010, 3'b001, 3'b000));
      end
    end
    emit_halt();
    start_program("conditional_jumps");
    finish_program();

    prog.delete();
    for (int k = 0; k < 12; k++) begin
      r = $random(seed);
      prog.push_back(a_ins(r[14:0]));
      prog.push_back(c_ins(1'b0, 6'b110000, 3'b010, 3'b000));
      prog.push_back(a_ins(15'(16'h4000 + k * 5)));
      prog.push_back(c_ins(1'b0, 6'b001100, 3'b001, 3'b000));
      prog.push_back(a_ins(15'(16'h4000 + k * 5)));  // Rereads the word from video RAM
      prog.push_back(c_ins(1'b1, 6'b110111, 3'b010, 3'b000));
      prog.push_back(a_ins(15'(16'h0020 + k)));
      prog.push_back(c_ins(1'b0, 6'b001100, 3'b001, 3'b000));
    end
    emit_halt();
    start_program("slow_region");
    finish_program();

    for (int p = 0; p < 3; p++) begin
      build_random(40);
      start_program($sformatf("random_program_%0d", p));
      finish_program();
    end

    build_random(30);
    start_program("reset_mid_run");
    repeat (60) @(posedge clk);
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    compare_pc(16'd0, pc);
    model_reset();
    set_limit();
    reset <= 1'b0;
    finish_program();

    $display("Mismatches %0d, other errors %0d", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+common
common/hack_pkg.sv
cpu/hack_alu.sv
cpu/hack_cpu.sv
logic/instr_rom.sv
logic/data_mem.sv
logic/hack_top.sv
verif/hack_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the Hack subsystem testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal --top-module hack_tb -f filelist.f -o hack_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/hack_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if ! grep -q "Testbench passed" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0
